// ==== Bender.yml ====
package:
  name: vic_timing

export_include_dirs:
  - hdl

sources:
  - hdl/vic_pkg.sv
  - hdl/phase_gen.sv
  - hdl/raster_counter.sv
  - hdl/sprite_ba_window.sv
  - hdl/bus_arbiter.sv
  - hdl/raster_irq.sv
  - hdl/vic_timing_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_vic_timing.sv

// ==== filelist.f ====
+incdir+hdl
hdl/vic_pkg.sv
hdl/phase_gen.sv
hdl/raster_counter.sv
hdl/sprite_ba_window.sv
hdl/bus_arbiter.sv
hdl/raster_irq.sv
hdl/vic_timing_top.sv
tests/tb_clock.sv
tests/tb_vic_timing.sv

// ==== hdl/bus_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vic_cfg.svh"

module bus_arbiter
   import vic_pkg::*;
(
   input  wire logic                        clk_dot4x,
   input  wire logic                        rst,
   input  wire phase_t                      phase_i,
   input  wire raster_t                     raster_i,
   input  wire logic                        den_i,
   input  wire logic [2:0]                  yscroll_i,
   input  wire logic [`VIC_NUM_SPRITES-1:0] sprite_ba_req_i,
   input  wire logic                        ce_i,
   input  wire logic                        rw_i,
   output logic                             ba_o,
   output logic                             aec_o,
   output logic                             vic_write_db_o,
   output logic                             vic_write_ab_o,
   output logic                             ls245_data_dir_o,
   output logic                             ls245_addr_dir_o
);

   localparam logic [8:0] BL_FIRST = 9'(`VIC_BADLINE_FIRST);
   localparam logic [8:0] BL_LAST  = 9'(`VIC_BADLINE_LAST);
   localparam logic [6:0] CH_FIRST = 7'(`VIC_CHARS_BA_FIRST_CYCLE);
   localparam logic [6:0] CH_END   = 7'(`VIC_CHARS_BA_END_CYCLE);

   logic       allow_bad_lines;
   logic [2:0] yscroll_q;
   logic       badline;
   logic       chars_ba_low;
   logic       ba1;
   logic       ba2;
   logic       ba3;

   // den only counts on line 48
   // also 49 cycle 0 when den moved at the very end of 48
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         allow_bad_lines <= 1'b0;
      end else if (phase_i.phi_rise) begin
         if (den_i && ((raster_i.line == BL_FIRST) ||
                       (raster_i.line == BL_FIRST + 9'd1 && raster_i.cycle_num == 7'd0))) begin
            allow_bad_lines <= 1'b1;
         end
         if (raster_i.line == BL_LAST) begin
            allow_bad_lines <= 1'b0;
         end
      end
   end

   // yscroll held from the start of phi high
   always_ff @(posedge clk_dot4x) begin
      if (phase_i.phi_rise) begin
         yscroll_q <= yscroll_i;
      end
   end

   assign badline = allow_bad_lines && (raster_i.line_d[2:0] == yscroll_q) &&
                    (raster_i.line_d >= BL_FIRST) && (raster_i.line_d < BL_LAST);

   // c-access window
   assign chars_ba_low = badline && (raster_i.cycle_num >= CH_FIRST) &&
                         (raster_i.cycle_num < CH_END);

   // any dma source pulls ba low
   assign ba_o = !(chars_ba_low || (|sprite_ba_req_i));

   // ba history sampled at the end of each phi high
   // ba3 falls on the third sample after ba drops
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ba1 <= 1'b1;
         ba2 <= 1'b1;
         ba3 <= 1'b1;
      end else if (phase_i.phi_late_high) begin
         ba1 <= ba_o;
         ba2 <= ba1 | ba_o;
         ba3 <= ba2 | ba_o;
      end
   end

   // cpu keeps phi high until the cascade runs out
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         aec_o <= 1'b0;
      end else begin
         aec_o <= ba_o ? phase_i.phi : (phase_i.phi & ba3);
      end
   end

   // cpu reads a register from us
   assign vic_write_db_o   = aec_o && rw_i && !ce_i;
   // aec low means the address bus is ours
   assign vic_write_ab_o   = !aec_o;
   assign ls245_data_dir_o = !vic_write_db_o;
   assign ls245_addr_dir_o = aec_o;

   // ba low over three late-high samples takes phi high away from the cpu
   a_aec_released: assert property (@(posedge clk_dot4x) disable iff (rst)
      ((!ba_o throughout phase_i.phi_late_high [->3]) ##1 !ba_o) |=> !aec_o)
      else $error("aec still high after three phi cycles of ba low");

endmodule

`default_nettype wire

// ==== hdl/phase_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vic_cfg.svh"

module phase_gen
   import vic_pkg::*;
(
   input  wire logic clk_dot4x,
   input  wire logic rst,
   output phase_t    phase_o,
   output logic      ras_o,
   output logic      cas_o
);

   localparam int TICKS = `VIC_TICKS_PER_PHI;
   localparam int HALF  = TICKS / 2;

   // drop pattern per half phase, msb goes out first
   localparam logic [HALF-1:0] RAS_PROFILE = {2'b11, {(HALF - 2){1'b0}}};
   localparam logic [HALF-1:0] CAS_PROFILE = {4'b1111, {(HALF - 4){1'b0}}};

   // one-hot position inside the phi cycle
   // bits below HALF are phi low, the rest phi high
   logic [TICKS-1:0] phi_pos;
   // one-hot dot position, bit 0 is the dot tick
   logic [3:0]       dot_gen;
   logic             phi_q;
   logic             edge_next;
   logic [HALF-1:0]  ras_prof;
   logic [HALF-1:0]  cas_prof;

   // last tick of either half, phi flips after it
   assign edge_next = phi_pos[HALF-1] | phi_pos[TICKS-1];

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         // start four ticks into phi low
         phi_pos  <= TICKS'(1) << 3;
         dot_gen  <= 4'b1000;
         phi_q    <= 1'b0;
         ras_prof <= '1;
         cas_prof <= '1;
      end else begin
         phi_pos <= {phi_pos[TICKS-2:0], phi_pos[TICKS-1]};
         dot_gen <= {dot_gen[2:0], dot_gen[3]};
         if (phi_pos[HALF-1]) begin
            phi_q <= 1'b1;
         end else if (phi_pos[TICKS-1]) begin
            phi_q <= 1'b0;
         end
         // both strobes go high again at each phi edge
         if (edge_next) begin
            ras_prof <= RAS_PROFILE;
            cas_prof <= CAS_PROFILE;
         end else begin
            ras_prof <= {ras_prof[HALF-2:0], 1'b0};
            cas_prof <= {cas_prof[HALF-2:0], 1'b0};
         end
      end
   end

   assign phase_o.phi           = phi_q;
   assign phase_o.phi_rise      = phi_pos[HALF];
   assign phase_o.phi_late_high = phi_pos[TICKS-1];
   // 4th tick of phi high
   assign phase_o.line_tick     = phi_pos[HALF+3];
   assign phase_o.dot_tick      = dot_gen[0];

   assign ras_o = ras_prof[HALF-1];
   assign cas_o = cas_prof[HALF-1];

   // dram needs the row latched before the column
   a_cas_after_ras: assert property (@(posedge clk_dot4x) disable iff (rst)
      $fell(cas_o) |-> !ras_o)
      else $error("cas fell while ras was high");

endmodule

`default_nettype wire

// ==== hdl/raster_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vic_cfg.svh"

module raster_counter
   import vic_pkg::*;
(
   input  wire logic       clk_dot4x,
   input  wire logic       rst,
   input  wire logic [1:0] chip_i,
   input  wire phase_t     phase_i,
   output raster_t         raster_o
);

   chip_limits_t lim;
   logic [9:0]   x_q;
   logic [8:0]   line_q;
   logic [8:0]   line_d_q;
   logic [6:0]   cycle_num;
   logic [9:0]   sprite_x;
   logic         line_d_load;

   assign lim = chip_limits(chip_i);

   // eight pixels per phi cycle
   assign cycle_num = x_q[9:3];

   // beam position, one pixel per dot tick
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         x_q    <= '0;
         line_q <= '0;
      end else if (phase_i.dot_tick) begin
         if (x_q >= lim.raster_x_max) begin
            x_q <= '0;
            if (line_q >= lim.raster_y_max) begin
               line_q <= '0;
            end else begin
               line_q <= line_q + 9'd1;
            end
         end else begin
            x_q <= x_q + 10'd1;
         end
      end
   end

   // line 0 shows up one cycle late, others in cycle 0
   assign line_d_load = phase_i.line_tick &&
                        ((line_q == 9'd0) ? (cycle_num == 7'd1) : (cycle_num == 7'd0));

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         line_d_q <= '0;
      end else if (line_d_load) begin
         line_d_q <= line_q;
      end
   end

   // shift x so sprite 0 ba drop sits at zero
   // keeps the sprite windows free of wrap around
   always_comb begin
      if (x_q >= lim.sprite_ba_origin) begin
         sprite_x = x_q - lim.sprite_ba_origin;
      end else begin
         sprite_x = x_q + lim.raster_x_max + 10'd1 - lim.sprite_ba_origin;
      end
   end

   assign raster_o = '{x: x_q, line: line_q, line_d: line_d_q,
                       cycle_num: cycle_num, sprite_x: sprite_x};

   // wrap must happen on the last pixel of the line
   a_x_in_range: assert property (@(posedge clk_dot4x) disable iff (rst)
      x_q <= lim.raster_x_max)
      else $error("raster x beyond chip limit");

endmodule

`default_nettype wire

// ==== hdl/raster_irq.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vic_cfg.svh"

module raster_irq
   import vic_pkg::*;
(
   input  wire logic       clk_dot4x,
   input  wire logic       rst,
   input  wire phase_t     phase_i,
   input  wire raster_t    raster_i,
   input  wire logic [8:0] raster_irq_compare_i,
   input  wire logic       erst_i,
   input  wire logic       irst_clr_i,
   output logic            irq_o
);

   // latched raster irq source
   logic irst;
   // set once the current line has fired
   logic triggered;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         irst      <= 1'b0;
         triggered <= 1'b0;
      end else begin
         // delayed line gives cycle 1 for line 0, cycle 0 otherwise
         if (phase_i.line_tick) begin
            if (raster_i.line_d == raster_irq_compare_i) begin
               if (!triggered) begin
                  triggered <= 1'b1;
                  irst      <= 1'b1;
               end
            end else begin
               triggered <= 1'b0;
            end
         end
         // clear wins over a set in the same tick
         if (irst_clr_i) begin
            irst <= 1'b0;
         end
      end
   end

   // source latches even with the enable off
   assign irq_o = irst & erst_i;

endmodule

`default_nettype wire

// ==== hdl/sprite_ba_window.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vic_cfg.svh"

module sprite_ba_window
   import vic_pkg::*;
#(
   parameter int SLOT = 0
) (
   input  wire logic clk_dot4x,
   input  wire logic rst,
   input  wire phase_t  phase_i,
   input  wire raster_t raster_i,
   input  wire logic dma_i,
   output logic      ba_req_o
);

   // window bounds in sprite_x, end exclusive
   localparam logic [9:0] WIN_START = 10'(SLOT * `VIC_SPRITE_BA_STEP);
   localparam logic [9:0] WIN_END   = 10'(SLOT * `VIC_SPRITE_BA_STEP + `VIC_SPRITE_BA_LEN);

   logic dma_q;
   logic in_window;

   assign in_window = (raster_i.sprite_x >= WIN_START) && (raster_i.sprite_x < WIN_END);

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         dma_q    <= 1'b0;
         ba_req_o <= 1'b0;
      end else begin
         // dma enable sampled as phi goes high
         if (phase_i.phi_rise) begin
            dma_q <= dma_i;
         end
         ba_req_o <= dma_q && in_window;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/vic_cfg.svh ====
`ifndef VIC_CFG_SVH
`define VIC_CFG_SVH

// chip model codes as seen on the chip_i pins
// code 3 is unused and falls back to 6569 limits
`define VIC_CHIP_6567R8          2'd0
`define VIC_CHIP_6569            2'd1
`define VIC_CHIP_6567R56A        2'd2

// number of sprite slots with their own dma window
`define VIC_NUM_SPRITES          8

// clk_dot4x ticks in one phi cycle
// first half is phi low, second half is phi high
`define VIC_TICKS_PER_PHI        32

// sprite ba windows in sprite_x pixels
`define VIC_SPRITE_BA_STEP       16
`define VIC_SPRITE_BA_LEN        40

// lines where a badline may happen, last is exclusive
`define VIC_BADLINE_FIRST        48
`define VIC_BADLINE_LAST         248

// c-access ba window in cycle numbers, end is exclusive
`define VIC_CHARS_BA_FIRST_CYCLE 12
`define VIC_CHARS_BA_END_CYCLE   55

`endif

// ==== hdl/vic_pkg.sv ====
`default_nettype none

`include "vic_cfg.svh"

package vic_pkg;

   // per chip beam limits
   typedef struct packed {
      logic [9:0] raster_x_max;
      logic [8:0] raster_y_max;
      // raster_x where sprite 0 drops ba
      logic [9:0] sprite_ba_origin;
   } chip_limits_t;

   // phase strobes, all single tick except phi
   typedef struct packed {
      logic phi;
      logic phi_rise;
      logic phi_late_high;
      logic line_tick;
      logic dot_tick;
   } phase_t;

   // beam position as seen by every block
   typedef struct packed {
      logic [9:0] x;
      logic [8:0] line;
      logic [8:0] line_d;
      logic [6:0] cycle_num;
      logic [9:0] sprite_x;
   } raster_t;

   function automatic chip_limits_t chip_limits(input logic [1:0] chip);
      chip_limits_t lim;
      case (chip)
         `VIC_CHIP_6567R8: begin
            // 520 pixels, 263 lines
            lim.raster_x_max     = 10'd519;
            lim.raster_y_max     = 9'd262;
            lim.sprite_ba_origin = 10'd432;
         end
         `VIC_CHIP_6567R56A: begin
            // 512 pixels, 262 lines
            lim.raster_x_max     = 10'd511;
            lim.raster_y_max     = 9'd261;
            lim.sprite_ba_origin = 10'd432;
         end
         default: begin
            // 6569 and the unused code, 504 pixels, 312 lines
            lim.raster_x_max     = 10'd503;
            lim.raster_y_max     = 9'd311;
            lim.sprite_ba_origin = 10'd424;
         end
      endcase
      return lim;
   endfunction

endpackage

`default_nettype wire

// ==== hdl/vic_timing_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vic_cfg.svh"

module vic_timing_top
   import vic_pkg::*;
(
   input  wire logic                        clk_dot4x,
   input  wire logic                        rst,
   input  wire logic [1:0]                  chip_i,
   input  wire logic                        den_i,
   input  wire logic [2:0]                  yscroll_i,
   input  wire logic [`VIC_NUM_SPRITES-1:0] sprite_dma_i,
   input  wire logic [8:0]                  raster_irq_compare_i,
   input  wire logic                        erst_i,
   input  wire logic                        irst_clr_i,
   input  wire logic                        ce_i,
   input  wire logic                        rw_i,
   output logic                             clk_phi_o,
   output logic [9:0]                       raster_x_o,
   output logic [8:0]                       raster_line_o,
   output logic                             ras_o,
   output logic                             cas_o,
   output logic                             ba_o,
   output logic                             aec_o,
   output logic                             irq_o,
   output logic                             vic_write_db_o,
   output logic                             vic_write_ab_o,
   output logic                             ls245_data_dir_o,
   output logic                             ls245_addr_dir_o
);

   phase_t                      phase;
   raster_t                     raster;
   logic [`VIC_NUM_SPRITES-1:0] sprite_ba_req;

   phase_gen phase_gen_i (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .phase_o   (phase),
      .ras_o     (ras_o),
      .cas_o     (cas_o)
   );

   raster_counter raster_counter_i (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .chip_i    (chip_i),
      .phase_i   (phase),
      .raster_o  (raster)
   );

   // one ba window per sprite slot
   for (genvar n = 0; n < `VIC_NUM_SPRITES; n++) begin : g_sprite_ba
      sprite_ba_window #(
         .SLOT (n)
      ) sprite_ba_window_i (
         .clk_dot4x (clk_dot4x),
         .rst       (rst),
         .phase_i   (phase),
         .raster_i  (raster),
         .dma_i     (sprite_dma_i[n]),
         .ba_req_o  (sprite_ba_req[n])
      );
   end

   bus_arbiter bus_arbiter_i (
      .clk_dot4x        (clk_dot4x),
      .rst              (rst),
      .phase_i          (phase),
      .raster_i         (raster),
      .den_i            (den_i),
      .yscroll_i        (yscroll_i),
      .sprite_ba_req_i  (sprite_ba_req),
      .ce_i             (ce_i),
      .rw_i             (rw_i),
      .ba_o             (ba_o),
      .aec_o            (aec_o),
      .vic_write_db_o   (vic_write_db_o),
      .vic_write_ab_o   (vic_write_ab_o),
      .ls245_data_dir_o (ls245_data_dir_o),
      .ls245_addr_dir_o (ls245_addr_dir_o)
   );

   raster_irq raster_irq_i (
      .clk_dot4x            (clk_dot4x),
      .rst                  (rst),
      .phase_i              (phase),
      .raster_i             (raster),
      .raster_irq_compare_i (raster_irq_compare_i),
      .erst_i               (erst_i),
      .irst_clr_i           (irst_clr_i),
      .irq_o                (irq_o)
   );

   // beam position and phi for the outside world
   assign clk_phi_o     = phase.phi;
   assign raster_x_o    = raster.x;
   assign raster_line_o = raster.line;

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 5
) (
   input  wire logic rst_req_i,
   output logic      clk_o,
   output logic      rst_o
);

   // rising edges still to be covered by reset
   int hold = RESET_CYCLES;

   initial begin
      clk_o = 1'b0;
      rst_o = 1'b1;
   end

   always #(PERIOD_NS / 2) clk_o = ~clk_o;

   // reset moves on the falling edge like every other dut input
   // a request restarts the whole pulse
   always @(negedge clk_o) begin
      if (rst_req_i) begin
         hold = RESET_CYCLES;
      end
      if (hold != 0) begin
         rst_o <= 1'b1;
         hold = hold - 1;
      end else begin
         rst_o <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== tests/tb_vic_timing.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vic_cfg.svh"

module tb_vic_timing;

   localparam int NUM_ROWS = 4;

   // one scenario per row, irq_rises is the expected count
   typedef struct packed {
      logic [1:0] chip;
      logic       den;
      logic [2:0] yscroll;
      logic [7:0] dma;
      logic [8:0] compare;
      logic       erst;
      logic [1:0] irq_rises;
   } row_t;

   row_t rows [NUM_ROWS];

   logic       clk_dot4x;
   logic       rst;
   logic       rst_req;
   logic [1:0] chip;
   logic       den;
   logic [2:0] yscroll;
   logic [7:0] sprite_dma;
   logic [8:0] compare_line;
   logic       erst;
   logic       irst_clr;
   logic       ce;
   logic       rw;
   logic       clk_phi_o;
   logic [9:0] raster_x_o;
   logic [8:0] raster_line_o;
   logic       ras_o;
   logic       cas_o;
   logic       ba_o;
   logic       aec_o;
   logic       irq_o;
   logic       vic_write_db_o;
   logic       vic_write_ab_o;
   logic       ls245_data_dir_o;
   logic       ls245_addr_dir_o;

   // reference model state, mirrors the dut after each rising edge
   int         pos;
   logic       edge_seen;
   int         x;
   int         line;
   int         line_d;
   logic [7:0] dma_q;
   logic [7:0] ba_req;
   logic       allow;
   logic [2:0] ys_q;
   logic [2:0] ba_hist;
   logic       aec_m;
   logic       irst_m;
   logic       trig_m;
   int         x_max;
   int         y_max;
   int         origin;
   int         lines_done;
   int         irq_rises;
   logic       irq_prev;

   tb_clock #(
      .PERIOD_NS    (40),
      .RESET_CYCLES (5)
   ) tb_clock_i (
      .rst_req_i (rst_req),
      .clk_o     (clk_dot4x),
      .rst_o     (rst)
   );

   vic_timing_top vic_timing_top_i (
      .clk_dot4x            (clk_dot4x),
      .rst                  (rst),
      .chip_i               (chip),
      .den_i                (den),
      .yscroll_i            (yscroll),
      .sprite_dma_i         (sprite_dma),
      .raster_irq_compare_i (compare_line),
      .erst_i               (erst),
      .irst_clr_i           (irst_clr),
      .ce_i                 (ce),
      .rw_i                 (rw),
      .clk_phi_o            (clk_phi_o),
      .raster_x_o           (raster_x_o),
      .raster_line_o        (raster_line_o),
      .ras_o                (ras_o),
      .cas_o                (cas_o),
      .ba_o                 (ba_o),
      .aec_o                (aec_o),
      .irq_o                (irq_o),
      .vic_write_db_o       (vic_write_db_o),
      .vic_write_ab_o       (vic_write_ab_o),
      .ls245_data_dir_o     (ls245_data_dir_o),
      .ls245_addr_dir_o     (ls245_addr_dir_o)
   );

   function automatic logic [31:0] next_random(input logic [31:0] s);
      logic [31:0] v;
      v = s;
      v = v ^ (v << 13);
      v = v ^ (v >> 17);
      v = v ^ (v << 5);
      return v;
   endfunction

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
         $display("Test failed");
         $fatal(1, "stopping at first error");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timeout while waiting for %s", what);
      $display("Test failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic set_row(input int idx, input row_t r);
      rows[idx] = r;
   endtask

   // beam limits per chip model
   task automatic set_limits(input logic [1:0] c);
      case (c)
         `VIC_CHIP_6567R8: begin
            x_max  = 519;
            y_max  = 262;
            origin = 432;
         end
         `VIC_CHIP_6567R56A: begin
            x_max  = 511;
            y_max  = 261;
            origin = 432;
         end
         default: begin
            x_max  = 503;
            y_max  = 311;
            origin = 424;
         end
      endcase
   endtask

   // x relative to the sprite 0 ba drop, modulo line length
   function automatic int sprite_x_of(input int px);
      return (px + x_max + 1 - origin) % (x_max + 1);
   endfunction

   function automatic logic ba_expected();
      logic bad;
      int   cyc;
      cyc = x / 8;
      bad = allow && (line_d % 8 == ys_q) &&
            (line_d >= `VIC_BADLINE_FIRST) && (line_d < `VIC_BADLINE_LAST);
      return !((bad && cyc >= `VIC_CHARS_BA_FIRST_CYCLE && cyc < `VIC_CHARS_BA_END_CYCLE) ||
               (|ba_req));
   endfunction

   task automatic reset_model();
      // phi low, four ticks into the low half
      pos       = 3;
      edge_seen = 1'b0;
      x         = 0;
      line      = 0;
      line_d    = 0;
      dma_q     = '0;
      ba_req    = '0;
      allow     = 1'b0;
      ba_hist   = 3'b111;
      aec_m     = 1'b0;
      irst_m    = 1'b0;
      trig_m    = 1'b0;
   endtask

   // one dot4x tick with the inputs that were applied at it
   task automatic advance_model();
      int         old_pos;
      int         old_x;
      int         old_line;
      int         old_cycle;
      int         sx;
      int         n;
      logic       old_ba;
      logic       old_phi;
      logic [7:0] req_next;
      old_pos   = pos;
      old_x     = x;
      old_line  = line;
      old_cycle = x / 8;
      old_ba    = ba_expected();
      old_phi   = (pos >= 16);
      sx        = sprite_x_of(x);
      for (n = 0; n < `VIC_NUM_SPRITES; n++) begin
         req_next[n] = dma_q[n] && (sx >= n * `VIC_SPRITE_BA_STEP) &&
                       (sx < n * `VIC_SPRITE_BA_STEP + `VIC_SPRITE_BA_LEN);
      end
      // aec tracks phi, held for three phi-high samples after ba drops
      aec_m = old_phi && (old_ba || (|ba_hist));
      if (old_pos == 31) begin
         ba_hist = {ba_hist[1:0], old_ba};
      end
      if (old_pos == 16) begin
         if (den && (old_line == 48 || (old_line == 49 && old_cycle == 0))) begin
            allow = 1'b1;
         end
         if (old_line == 248) begin
            allow = 1'b0;
         end
         ys_q  = yscroll;
         dma_q = sprite_dma;
      end
      // raster compare on the 4th tick of phi high
      if (old_pos == 19) begin
         if (line_d == compare_line) begin
            if (!trig_m) begin
               trig_m = 1'b1;
               irst_m = 1'b1;
            end
         end else begin
            trig_m = 1'b0;
         end
         if ((old_line == 0) ? (old_cycle == 1) : (old_cycle == 0)) begin
            line_d = old_line;
         end
      end
      if (irst_clr) begin
         irst_m = 1'b0;
      end
      if (old_pos % 4 == 0) begin
         if (old_x == x_max) begin
            x          = 0;
            lines_done = lines_done + 1;
            line       = (old_line == y_max) ? 0 : old_line + 1;
         end else begin
            x = old_x + 1;
         end
      end
      pos    = (old_pos + 1) % `VIC_TICKS_PER_PHI;
      ba_req = req_next;
      if (pos % 16 == 0) begin
         edge_seen = 1'b1;
      end
   endtask

   task automatic check_outputs();
      logic db;
      db = aec_m && rw && !ce;
      compare("clk_phi_o", clk_phi_o, pos >= 16);
      // both strobes idle high until the first phi edge
      compare("ras_o", ras_o, edge_seen ? (pos % 16 < 2) : 1);
      compare("cas_o", cas_o, edge_seen ? (pos % 16 < 4) : 1);
      compare("raster_x_o", raster_x_o, x);
      compare("raster_line_o", raster_line_o, line);
      compare("ba_o", ba_o, ba_expected());
      compare("aec_o", aec_o, aec_m);
      compare("irq_o", irq_o, irst_m && erst);
      compare("vic_write_db_o", vic_write_db_o, db);
      compare("vic_write_ab_o", vic_write_ab_o, !aec_m);
      compare("ls245_data_dir_o", ls245_data_dir_o, !db);
      compare("ls245_addr_dir_o", ls245_addr_dir_o, aec_m);
      if (irq_o && !irq_prev) begin
         irq_rises = irq_rises + 1;
      end
      irq_prev = irq_o;
   endtask

   initial begin
      int          row;
      int          ticks;
      int          limit;
      int          waited;
      logic [31:0] rnd;
      chip         = '0;
      den          = 1'b0;
      yscroll      = '0;
      sprite_dma   = '0;
      compare_line = '0;
      erst         = 1'b0;
      irst_clr     = 1'b0;
      ce           = 1'b1;
      rw           = 1'b1;
      rst_req      = 1'b0;
      ys_q         = '0;
      rnd          = 32'h509c;
      // chip, den, yscroll, dma mask, compare line, erst, expected irq rises
      set_row(0, '{`VIC_CHIP_6569, 1'b1, 3'd3, 8'h00, 9'd100, 1'b1, 2'd1});
      set_row(1, '{`VIC_CHIP_6567R8, 1'b1, 3'd0, 8'ha5, 9'd0, 1'b1, 2'd2});
      set_row(2, '{`VIC_CHIP_6567R56A, 1'b1, 3'd7, 8'hff, 9'd261, 1'b0, 2'd0});
      set_row(3, '{2'd3, 1'b0, 3'd5, 8'h18, 9'd311, 1'b1, 2'd1});
      for (row = 0; row < NUM_ROWS; row++) begin
         @(negedge clk_dot4x);
         chip         <= rows[row].chip;
         den          <= rows[row].den;
         yscroll      <= rows[row].yscroll;
         sprite_dma   <= rows[row].dma;
         compare_line <= rows[row].compare;
         erst         <= rows[row].erst;
         rst_req      <= 1'b1;
         set_limits(rows[row].chip);
         @(negedge clk_dot4x);
         rst_req <= 1'b0;
         waited = 0;
         while (rst !== 1'b1) begin
            if (waited > 10) begin
               report_timeout("reset");
            end
            @(negedge clk_dot4x);
            waited++;
         end
         reset_model();
         lines_done = 0;
         irq_rises  = 0;
         irq_prev   = 1'b0;
         check_outputs();
         ticks = 0;
         limit = (y_max + 4) * (x_max + 1) * 4;
         // one full frame plus two lines
         while (lines_done < y_max + 3) begin
            if (ticks > limit) begin
               report_timeout("frame end");
            end
            // new cpu bus cycle at each phi period
            if (pos == 0) begin
               rnd = next_random(rnd);
               ce <= rnd[0];
               rw <= rnd[1];
            end
            irst_clr <= (pos == 0) && (x / 8 == 40);
            @(negedge clk_dot4x);
            ticks++;
            if (rst) begin
               reset_model();
            end else begin
               advance_model();
            end
            check_outputs();
         end
         compare("irq rise count", irq_rises, rows[row].irq_rises);
         $display("row %0d done after %0d ticks", row, ticks);
      end
      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire
